// ==== fv_sram.f ====
src/fv_pkg.sv
src/fv_req_fifo.sv
src/fv_mem_cntl.sv
src/fv_bank_cntl.sv
src/fv_sram_bank.sv
src/fv_bus.sv
src/fv_sram_top.sv
sim/fv_sram_tb.sv

// ==== sim/fv_golden.txt ====
# n num_fv | l bank row data | r pe_tag fv_addr expected | g mode (s spaced, c back to back, b burst)
# all values hex, fv_addr is the flat index row*4+bank
n 20
l 0 0 a0a0
l 1 0 b1b1
l 1 1 b2b2
l 1 2 b3b3
l 2 1 c2c2
l 3 2 d3d3
r 0 000 a0a0
r 1 005 b2b2
r 2 006 c2c2
r 3 00b d3d3
r 2 009 b3b3
r 3 021 0000
r 0 3fe 0000
g s
r 1 000 a0a0
r 1 021 0000
r 1 006 c2c2
r 1 3ff 0000
g c
r 3 001 b1b1
r 3 005 b2b2
r 3 009 b3b3
r 3 025 0000
r 3 001 b1b1
r 3 009 b3b3
r 3 005 b2b2
g b

// ==== sim/fv_sram_tb.sv ====
// Self-checking testbench for fv_sram_top that reads its stimulus and expected data from sim/fv_golden.txt.
`timescale 1ns/1ns

module fv_sram_tb;

    logic                                        clk;
    logic                                        rst;
    fv_pkg::fv_req_t                             wdata;
    logic [fv_pkg::num_fv_w-1:0]                 num_fv;
    fv_pkg::fv_load_t [fv_pkg::num_banks-1:0]    load_in;
    fv_pkg::fv_pe_out_t [fv_pkg::num_pe-1:0]     pe_out;
    logic                                        wfull;

    int                 fd;
    int                 code;
    int                 f0;
    int                 f1;
    int                 f2;
    int                 pulse_cnt;
    int                 nreq_total;
    logic               saw_full;
    string              cmd;
    string              line;
    int                 grp_tag[$];
    int                 grp_addr[$];
    int                 grp_exp[$];
    int                 got_pe[$];
    fv_pkg::fv_pe_out_t got_out[$];

    // a small FIFO makes a single-bank burst reach wfull quickly.
    fv_sram_top #(.fifo_depth(4)) dut_i (
        .clk(clk), .rst(rst), .wdata(wdata), .num_fv(num_fv),
        .load_in(load_in), .pe_out(pe_out), .wfull(wfull)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < fv_pkg::num_pe; p++) begin
                if (pe_out[p].valid) begin
                    got_out.push_back(pe_out[p]);
                    got_pe.push_back(p);
                    pulse_cnt++;
                end
            end
            if (wfull) begin
                saw_full = 1'b1;
            end
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_pe_out(input fv_pkg::fv_pe_out_t got,
                                input logic [fv_pkg::fv_w-1:0] exp, input int pe);
        if (got.valid !== 1'b1 || got.data !== exp) begin
            fail_run($sformatf("mismatch pe_out[%0d].data got %h expected %h",
                               pe, got.data, exp));
        end
    endtask

    task automatic load_word(input int bank, input int row, input int data);
        load_in[bank].valid = 1'b1;
        load_in[bank].row   = row[fv_pkg::row_w-1:0];
        load_in[bank].data  = data[fv_pkg::fv_w-1:0];
        idle_cycles(1);
        load_in[bank] = '0;
    endtask

    task automatic send_req(input int tag, input int addr);
        int waited;
        waited = 0;
        while (wfull) begin // the source holds off while the FIFO is full.
            idle_cycles(1);
            waited++;
            if (waited > 100) begin
                fail_run("timeout: wfull stayed high while a request was waiting");
            end
        end
        wdata.valid        = 1'b1;
        wdata.pe_tag       = tag[fv_pkg::tag_w-1:0];
        wdata.fv_addr.flat = addr[fv_pkg::addr_w-1:0];
        idle_cycles(1);
        wdata.valid = 1'b0;
    endtask

    // mode s spaces requests randomly, c sends them back to back, b is an in-order burst.
    task automatic run_group(input string mode);
        int waited;
        int idx;
        saw_full = 1'b0;
        for (int i = 0; i < grp_tag.size(); i++) begin
            send_req(grp_tag[i], grp_addr[i]);
            if (mode == "s") begin
                idle_cycles($urandom_range(3, 0));
            end
        end
        nreq_total += grp_tag.size();
        waited = 0;
        while (pulse_cnt < nreq_total) begin
            idle_cycles(1);
            waited++;
            if (waited > 200) begin
                fail_run("timeout: not every request of the group reached its PE output");
            end
        end
        for (int i = 0; i < grp_tag.size(); i++) begin
            idx = -1;
            for (int k = 0; k < got_out.size(); k++) begin
                if (idx < 0 && got_pe[k] == grp_tag[i] &&
                    (mode == "b" || got_out[k].data == grp_exp[i][fv_pkg::fv_w-1:0])) begin
                    idx = k;
                end
            end
            for (int k = 0; k < got_out.size(); k++) begin
                if (idx < 0 && got_pe[k] == grp_tag[i]) begin
                    idx = k;
                end
            end
            if (idx < 0) begin
                fail_run($sformatf("no pulse arrived on PE %0d for address %h",
                                   grp_tag[i], grp_addr[i]));
            end
            check_pe_out(got_out[idx], grp_exp[i][fv_pkg::fv_w-1:0], grp_tag[i]);
            got_out.delete(idx);
            got_pe.delete(idx);
        end
        if (got_out.size() != 0) begin
            fail_run("a PE output pulsed more often than requests were sent to it");
        end
        if (mode == "b") begin
            check_flag("wfull_seen", saw_full, 1'b1);
        end
        grp_tag.delete();
        grp_addr.delete();
        grp_exp.delete();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        wdata      = '0;
        num_fv     = '0;
        load_in    = '0;
        pulse_cnt  = 0;
        nreq_total = 0;
        saw_full   = 1'b0;
        void'($urandom(98429));
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int c = 0; c < 6; c++) begin
            check_flag("wfull", wfull, 1'b0);
            for (int p = 0; p < fv_pkg::num_pe; p++) begin
                check_flag($sformatf("pe_out[%0d].valid", p), pe_out[p].valid, 1'b0);
            end
            idle_cycles(1);
        end
        fd = $fopen("sim/fv_golden.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the golden file sim/fv_golden.txt");
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd.getc(0) == "#") begin
                code = $fgets(line, fd);
            end else if (cmd == "n") begin
                code = $fscanf(fd, "%h", f0);
                if (code != 1) begin
                    fail_run("a num_fv record in the golden file is incomplete");
                end
                num_fv = f0[fv_pkg::num_fv_w-1:0];
            end else if (cmd == "l") begin
                code = $fscanf(fd, "%h %h %h", f0, f1, f2);
                if (code != 3) begin
                    fail_run("a load record in the golden file is incomplete");
                end
                load_word(f0, f1, f2);
            end else if (cmd == "r") begin
                code = $fscanf(fd, "%h %h %h", f0, f1, f2);
                if (code != 3) begin
                    fail_run("a request record in the golden file is incomplete");
                end
                grp_tag.push_back(f0);
                grp_addr.push_back(f1);
                grp_exp.push_back(f2);
            end else if (cmd == "g") begin
                code = $fscanf(fd, "%s", line);
                if (code != 1) begin
                    fail_run("a group record in the golden file has no mode");
                end
                run_group(line);
            end else begin
                fail_run($sformatf("unknown record %s in the golden file", cmd));
            end
        end
        $fclose(fd);
        idle_cycles(20); // nothing more may arrive during the drain window.
        if (pulse_cnt != nreq_total) begin
            fail_run($sformatf("mismatch pulse_cnt got %h expected %h", pulse_cnt, nreq_total));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== src/fv_sram_top.sv ====
// Top level of the feature-vector store: request FIFO, controller, banks and output bus.
`timescale 1ns/1ns

module fv_sram_top #(
    parameter int fifo_depth = 8
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  fv_pkg::fv_req_t                             wdata,
    input  logic [fv_pkg::num_fv_w-1:0]                 num_fv,
    input  fv_pkg::fv_load_t [fv_pkg::num_banks-1:0]    load_in,
    output fv_pkg::fv_pe_out_t [fv_pkg::num_pe-1:0]     pe_out,
    output logic                                        wfull
);

    fv_pkg::fv_req_t                                   head;
    logic                                              rempty;
    logic                                              rinc;
    logic [fv_pkg::num_banks-1:0]                      bank_busy;
    logic [fv_pkg::num_banks-1:0]                      grant;
    fv_pkg::fv_dispatch_t [fv_pkg::num_banks-1:0]      dispatch;
    fv_pkg::fv_sram_if_t [fv_pkg::num_banks-1:0]       sram;
    fv_pkg::fv_result_t [fv_pkg::num_banks-1:0]        result;
    logic [fv_pkg::num_banks-1:0][fv_pkg::fv_w-1:0]    q;

    fv_req_fifo #(.depth(fifo_depth)) fifo_i (
        .clk(clk), .rst(rst), .wdata(wdata), .rinc(rinc),
        .rdata(head), .wfull(wfull), .rempty(rempty)
    );

    fv_mem_cntl mem_cntl_i (
        .clk(clk), .rst(rst), .head(head), .rempty(rempty),
        .bank_busy(bank_busy), .rinc(rinc), .dispatch(dispatch)
    );

    for (genvar b = 0; b < fv_pkg::num_banks; b++) begin : bank_gen
        fv_bank_cntl bank_cntl_i (
            .clk(clk), .rst(rst), .num_fv(num_fv), .dispatch(dispatch[b]),
            .load(load_in[b]), .q(q[b]), .grant(grant[b]),
            .sram(sram[b]), .result(result[b]), .busy(bank_busy[b])
        );

        fv_sram_bank sram_i (
            .clk(clk), .cen(sram[b].cen), .wen(sram[b].wen),
            .a(sram[b].a), .d(sram[b].d), .q(q[b])
        );
    end

    fv_bus bus_i (
        .clk(clk), .rst(rst), .result(result), .grant(grant), .pe_out(pe_out)
    );

endmodule

// ==== src/fv_bus.sv ====
// Output bus with a round-robin arbiter per PE over the bank results, registered PE outputs.
`timescale 1ns/1ns

module fv_bus (
    input  logic                                         clk,
    input  logic                                         rst,
    input  fv_pkg::fv_result_t [fv_pkg::num_banks-1:0]   result,
    output logic [fv_pkg::num_banks-1:0]                 grant,
    output fv_pkg::fv_pe_out_t [fv_pkg::num_pe-1:0]      pe_out
);

    logic [fv_pkg::num_pe-1:0][fv_pkg::num_banks-1:0] req;
    logic [fv_pkg::num_pe-1:0][fv_pkg::bank_w-1:0]    rr_ptr;
    logic [fv_pkg::num_pe-1:0][fv_pkg::bank_w-1:0]    win_idx;
    logic [fv_pkg::num_pe-1:0]                        win_vld;

    always_comb begin
        for (int p = 0; p < fv_pkg::num_pe; p++) begin
            for (int b = 0; b < fv_pkg::num_banks; b++) begin
                req[p][b] = result[b].valid &&
                            (result[b].pe_tag == p[fv_pkg::tag_w-1:0]);
            end
        end
    end

    // search starts at the pointer, so the last winner goes to the back.
    always_comb begin
        logic [fv_pkg::bank_w-1:0] cand;
        grant = '0;
        for (int p = 0; p < fv_pkg::num_pe; p++) begin
            win_vld[p] = 1'b0;
            win_idx[p] = '0;
            for (int i = 0; i < fv_pkg::num_banks; i++) begin
                cand = rr_ptr[p] + i[fv_pkg::bank_w-1:0];
                if (!win_vld[p] && req[p][cand]) begin
                    win_vld[p] = 1'b1;
                    win_idx[p] = cand;
                end
            end
            if (win_vld[p]) begin
                grant[win_idx[p]] = 1'b1; // one tag per bank, so grants never collide.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
            for (int p = 0; p < fv_pkg::num_pe; p++) begin
                pe_out[p].valid <= 1'b0;
            end
        end else begin
            for (int p = 0; p < fv_pkg::num_pe; p++) begin
                pe_out[p].valid <= win_vld[p];
                pe_out[p].data  <= result[win_idx[p]].data;
                if (win_vld[p]) begin
                    rr_ptr[p] <= win_idx[p] + 1'b1;
                end
            end
        end
    end

    for (genvar b = 0; b < fv_pkg::num_banks; b++) begin : grant_chk_gen
        grant_to_valid: assert property (@(posedge clk) disable iff (rst)
            grant[b] |-> result[b].valid);
    end

endmodule

// ==== src/fv_sram_bank.sv ====
// Behavioral model of one 256 x 16 single-port SRAM macro with active-low enables.
`timescale 1ns/1ns

module fv_sram_bank (
    input  logic                        clk,
    input  logic                        cen,
    input  logic                        wen,
    input  logic [fv_pkg::row_w-1:0]    a,
    input  logic [fv_pkg::fv_w-1:0]     d,
    output logic [fv_pkg::fv_w-1:0]     q
);

    logic [fv_pkg::fv_w-1:0] mem [2**fv_pkg::row_w];

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[a] <= d;
            end else begin
                q <= mem[a]; // q keeps its value on idle and write cycles.
            end
        end
    end

endmodule

// ==== src/fv_bank_cntl.sv ====
// Per-bank controller: sequences SRAM reads and load writes and holds a result for the bus.
`timescale 1ns/1ns

module fv_bank_cntl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [fv_pkg::num_fv_w-1:0]    num_fv,
    input  fv_pkg::fv_dispatch_t           dispatch,
    input  fv_pkg::fv_load_t               load,
    input  logic [fv_pkg::fv_w-1:0]        q,
    input  logic                           grant,
    output fv_pkg::fv_sram_if_t            sram,
    output fv_pkg::fv_result_t             result,
    output logic                           busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_capture,
        st_hold
    } bank_state_t;

    bank_state_t                 state;
    logic [fv_pkg::row_w-1:0]    row_q;
    logic [fv_pkg::tag_w-1:0]    tag_q;
    logic                        in_range;

    // the flat index is compared against the count of loaded vectors.
    assign in_range = ({1'b0, dispatch.fv_addr.flat} < num_fv);

    assign busy = (state != st_idle);

    // a load write always wins the port since it is only legal while idle.
    assign sram.cen = !((state == st_read) || load.valid);
    assign sram.wen = !load.valid;
    assign sram.a   = load.valid ? load.row : row_q;
    assign sram.d   = load.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            result.valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (dispatch.valid) begin
                        tag_q <= dispatch.pe_tag;
                        row_q <= dispatch.fv_addr.rb.row;
                        if (in_range) begin
                            state <= st_read;
                        end else begin
                            result.valid  <= 1'b1; // out of range answers zero at once.
                            result.pe_tag <= dispatch.pe_tag;
                            result.data   <= '0;
                            state         <= st_hold;
                        end
                    end
                end
                st_read: begin
                    state <= st_capture; // the macro returns q one edge later.
                end
                st_capture: begin
                    result.valid  <= 1'b1;
                    result.pe_tag <= tag_q;
                    result.data   <= q;
                    state         <= st_hold;
                end
                st_hold: begin
                    if (grant) begin
                        result.valid <= 1'b0;
                        state        <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    no_load_while_busy: assert property (@(posedge clk) disable iff (rst)
        load.valid |-> !busy);

    // the bus may sample a held result over several cycles of contention.
    result_stable_until_grant: assert property (@(posedge clk) disable iff (rst)
        (result.valid && !grant) |=> $stable(result));

endmodule

// ==== src/fv_mem_cntl.sv ====
// Memory controller that pops the FIFO head and dispatches it to its bank when free.
`timescale 1ns/1ns

module fv_mem_cntl (
    input  logic                                            clk,
    input  logic                                            rst,
    input  fv_pkg::fv_req_t                                 head,
    input  logic                                            rempty,
    input  logic [fv_pkg::num_banks-1:0]                    bank_busy,
    output logic                                            rinc,
    output fv_pkg::fv_dispatch_t [fv_pkg::num_banks-1:0]    dispatch
);

    logic [fv_pkg::bank_w-1:0]          sel;
    logic [fv_pkg::num_banks-1:0]       strobe;
    logic [fv_pkg::num_banks-1:0][15:0] disp_cnt;
    logic [15:0]                        cnt_sum;

    assign sel  = head.fv_addr.rb.bank;
    assign rinc = !rempty && head.valid && !bank_busy[sel]; // a busy bank stalls the queue.

    always_comb begin
        for (int b = 0; b < fv_pkg::num_banks; b++) begin
            strobe[b]          = rinc && (sel == b[fv_pkg::bank_w-1:0]);
            dispatch[b].valid  = strobe[b];
            dispatch[b].pe_tag = head.pe_tag;
            dispatch[b].fv_addr = head.fv_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_cnt <= '0;
        end else begin
            for (int b = 0; b < fv_pkg::num_banks; b++) begin
                if (strobe[b]) begin
                    disp_cnt[b] <= disp_cnt[b] + 16'd1;
                end
            end
        end
    end

    always_comb begin
        cnt_sum = '0;
        for (int b = 0; b < fv_pkg::num_banks; b++) begin
            cnt_sum = cnt_sum + disp_cnt[b];
        end
    end

    // every pop lands in exactly one bank count, so the total steps by one at most.
    one_dispatch_per_pop: assert property (@(posedge clk) disable iff (rst)
        $onehot0(strobe) ##1 (cnt_sum == $past(cnt_sum) + {15'd0, $past(rinc)}));

endmodule

// ==== src/fv_req_fifo.sv ====
// Show-ahead request FIFO between the PE request port and the memory controller.
`timescale 1ns/1ns

module fv_req_fifo #(
    parameter int depth = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  fv_pkg::fv_req_t  wdata,
    input  logic             rinc,
    output fv_pkg::fv_req_t  rdata,
    output logic             wfull,
    output logic             rempty
);

    localparam int ptr_w = $clog2(depth);

    fv_pkg::fv_req_t  mem [depth];
    logic [ptr_w:0]   wptr;
    logic [ptr_w:0]   rptr;
    logic             push;
    logic             pop;

    assign push = wdata.valid && !wfull;
    assign pop  = rinc && !rempty;

    // the extra pointer bit tells a full buffer from an empty one.
    assign rempty = (wptr == rptr);
    assign wfull  = (wptr[ptr_w] != rptr[ptr_w]) &&
                    (wptr[ptr_w-1:0] == rptr[ptr_w-1:0]);

    assign rdata = mem[rptr[ptr_w-1:0]]; // head is visible without a read strobe.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr[ptr_w-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    // the request source has to hold off while wfull is high.
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        !(wdata.valid && wfull));

    // the controller only pops a request it can see.
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        rinc |-> !rempty);

endmodule

// ==== src/fv_pkg.sv ====
// Shared widths, address union and bus structs for the feature-vector SRAM subsystem.
package fv_pkg;

    localparam int num_banks = 4;
    localparam int num_pe    = 4;
    localparam int fv_w      = 16;
    localparam int row_w     = 8;
    localparam int bank_w    = 2;
    localparam int addr_w    = row_w + bank_w;
    localparam int tag_w     = 2;
    localparam int num_fv_w  = 11;

    typedef struct packed {
        logic [row_w-1:0]  row;
        logic [bank_w-1:0] bank; // low bits interleave vectors across banks.
    } fv_row_bank_t;

    // the same address word is read as a flat index or as row and bank.
    typedef union packed {
        logic [addr_w-1:0] flat;
        fv_row_bank_t      rb;
    } fv_addr_u;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] pe_tag;
        fv_addr_u         fv_addr;
    } fv_req_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] pe_tag;
        fv_addr_u         fv_addr;
    } fv_dispatch_t;

    typedef struct packed {
        logic             valid;
        logic [row_w-1:0] row;
        logic [fv_w-1:0]  data;
    } fv_load_t;

    typedef struct packed {
        logic             cen; // active low.
        logic             wen; // active low.
        logic [row_w-1:0] a;
        logic [fv_w-1:0]  d;
    } fv_sram_if_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] pe_tag;
        logic [fv_w-1:0]  data;
    } fv_result_t;

    typedef struct packed {
        logic            valid;
        logic [fv_w-1:0] data;
    } fv_pe_out_t;

endpackage
